//--- design/bp_consts.svh
`ifndef BP_CONSTS_SVH
`define BP_CONSTS_SVH

////////////////////////////////////////////////////////////////////////////
// Branch target table geometry

// Sets per way
`define BP_ENTRIES 64

// Associativity of the table
`define BP_WAYS 2

// Tag bits, taken from the PC just above the set index
`define BP_TAG_W 16

////////////////////////////////////////////////////////////////////////////
// In-flight tracking and return stack

// Instruction ids in flight between fetch and execute
`define BP_MAX_IDS 8

// Return addresses kept before the oldest is overwritten
`define BP_RAS_DEPTH 4

`endif

//--- design/bp_table_pkg.sv
`default_nettype none

`include "bp_consts.svh"

package bp_table_pkg;

    // Set index and tag of a table lookup
    typedef logic [$clog2(`BP_ENTRIES)-1:0] set_index_t;
    typedef logic [`BP_TAG_W-1:0] btag_t;

    // 2-bit saturating direction counter, MSB is the predicted direction
    typedef logic [1:0] dir_counter_t;

    // One bit per way
    typedef logic [`BP_WAYS-1:0] way_mask_t;

    // Valid sits in the top bit so a never-written word reads as invalid
    typedef struct packed {
        logic valid;
        btag_t tag;
        logic is_branch;
        logic is_return;
        logic is_call;
        dir_counter_t counter;
    } bt_entry_t;

    // Lookup state kept until the branch resolves
    typedef struct packed {
        dir_counter_t counter;
        logic prediction_used;
        way_mask_t update_way;
    } id_meta_t;

endpackage

`default_nettype wire

//--- design/bp_fetch_pkg.sv
`default_nettype none

`include "bp_consts.svh"

package bp_fetch_pkg;

    typedef logic [31:0] addr_t;
    typedef logic [$clog2(`BP_MAX_IDS)-1:0] instr_id_t;

    ////////////////////////////////////////////////////////////////////////////
    // Fetch side

    // Cycle N, starts the table read
    typedef struct packed {
        addr_t next_pc;
        logic new_mem_request;
    } fetch_req_t;

    // Cycle N+1, the PC being fetched and the id it gets
    typedef struct packed {
        addr_t if_pc;
        instr_id_t pc_id;
        logic pc_id_assigned;
    } fetch_tag_t;

    typedef struct packed {
        addr_t predicted_pc;
        logic use_prediction;
        logic is_branch;
        logic is_return;
        logic is_call;
    } prediction_t;

    ////////////////////////////////////////////////////////////////////////////
    // Execute side

    // Single-cycle pulse on valid
    typedef struct packed {
        logic valid;
        instr_id_t id;
        addr_t pc;
        addr_t target_pc;
        logic branch_taken;
        logic is_branch;
        logic is_return;
        logic is_call;
    } branch_result_t;

endpackage

`default_nettype wire

//--- design/bp_ram.sv
`timescale 1ns/100ps
`default_nettype none

module bp_ram #(
    parameter int data_width = 32,
    parameter int depth = 64
) (
    input wire clk,
    input wire reset,
    input wire [$clog2(depth)-1:0] write_addr,
    input wire write_en,
    input wire [data_width-1:0] write_data,
    input wire [$clog2(depth)-1:0] read_addr,
    input wire read_en,
    output logic [data_width-1:0] read_data
);

    logic [data_width-1:0] mem [depth];

    // Tracks which words were written since reset
    logic [depth-1:0] written;

    always_ff @(posedge clk) begin
        if (write_en)
            mem[write_addr] <= write_data;
    end

    always_ff @(posedge clk) begin
        if (reset)
            written <= '0;
        else if (write_en)
            written[write_addr] <= 1'b1;
    end

    // Registered read, held while read_en is low
    always_ff @(posedge clk) begin
        if (reset)
            read_data <= '0;
        else if (read_en)
            read_data <= written[read_addr] ? mem[read_addr] : '0;
    end

    write_addr_in_range: assert property (@(posedge clk) disable iff (reset)
        write_en |-> (int'(write_addr) < depth))
        else $error("bp_ram write address out of range");

endmodule

`default_nettype wire

//--- design/way_cycler.sv
`timescale 1ns/100ps
`default_nettype none

module way_cycler #(
    parameter int ways = 2
) (
    input wire clk,
    input wire reset,
    output logic [ways-1:0] one_hot
);

    logic [ways-1:0] rotated;

    // Rotate left by one, top bit wraps to way 0
    always_comb begin
        for (int w = 0; w < ways; w++)
            rotated[w] = one_hot[(w + ways - 1) % ways];
    end

    always_ff @(posedge clk) begin
        if (reset)
            one_hot <= ways'(1);
        else
            one_hot <= rotated;
    end

    stays_one_hot: assert property (@(posedge clk) disable iff (reset) $onehot(one_hot))
        else $error("way_cycler lost its one-hot pointer");

endmodule

`default_nettype wire

//--- design/return_stack.sv
`timescale 1ns/100ps
`default_nettype none

`include "bp_consts.svh"

module return_stack
    import bp_fetch_pkg::*;
(
    input wire clk,
    input wire reset,
    input wire push,
    input wire pop,
    input wire addr_t push_addr,
    output addr_t top_addr,
    output logic empty
);

    localparam int PTR_W = $clog2(`BP_RAS_DEPTH);
    localparam int CNT_W = $clog2(`BP_RAS_DEPTH + 1);

    addr_t stack [`BP_RAS_DEPTH];

    logic [PTR_W-1:0] top_ptr;
    logic [PTR_W-1:0] next_ptr;
    logic [PTR_W-1:0] prev_ptr;
    logic [CNT_W-1:0] count;

    // Circular pointer arithmetic
    assign next_ptr = (top_ptr == PTR_W'(`BP_RAS_DEPTH - 1)) ? '0 : top_ptr + 1'b1;
    assign prev_ptr = (top_ptr == '0) ? PTR_W'(`BP_RAS_DEPTH - 1) : top_ptr - 1'b1;

    ////////////////////////////////////////////////////////////////////////////
    // Pointer and occupancy
    always_ff @(posedge clk) begin
        if (reset) begin
            top_ptr <= '0;
            count <= '0;
        end else if (push && !pop) begin
            top_ptr <= next_ptr;
            // Full stack drops its oldest entry
            if (count != CNT_W'(`BP_RAS_DEPTH))
                count <= count + 1'b1;
        end else if (pop && !push) begin
            top_ptr <= prev_ptr;
            count <= count - 1'b1;
        end
    end

    // Push with pop replaces the top in place
    always_ff @(posedge clk) begin
        if (push && pop)
            stack[top_ptr] <= push_addr;
        else if (push)
            stack[next_ptr] <= push_addr;
    end

    assign top_addr = stack[top_ptr];
    assign empty = (count == '0);

    no_pop_when_empty: assert property (@(posedge clk) disable iff (reset) pop |-> !empty)
        else $error("return_stack popped while empty");

endmodule

`default_nettype wire

//--- design/branch_predictor.sv
`timescale 1ns/100ps
`default_nettype none

`include "bp_consts.svh"

module branch_predictor
    import bp_table_pkg::*;
    import bp_fetch_pkg::*;
(
    input wire clk,
    input wire reset,
    input wire fetch_req_t fetch_req,
    input wire fetch_tag_t fetch_tag,
    input wire branch_result_t br_result,
    output prediction_t table_pred
);

    localparam int INDEX_W = $bits(set_index_t);

    function automatic set_index_t get_index(input addr_t pc);
        return pc[2 +: INDEX_W];
    endfunction

    function automatic btag_t get_tag(input addr_t pc);
        return pc[2 + INDEX_W +: `BP_TAG_W];
    endfunction

    bt_entry_t [`BP_WAYS-1:0] if_entry;
    addr_t [`BP_WAYS-1:0] if_target;
    bt_entry_t ex_entry;
    bt_entry_t hit_entry;
    addr_t hit_target;

    way_mask_t tag_matches;
    way_mask_t replacement_way;
    way_mask_t tag_update_way;
    way_mask_t target_update_way;
    logic hit;
    logic direction_changed;

    id_meta_t meta_table [`BP_MAX_IDS];
    id_meta_t meta_if;
    id_meta_t meta_ex;

    ////////////////////////////////////////////////////////////////////////////
    // Tag and target banks, one pair per way
    for (genvar w = 0; w < `BP_WAYS; w++) begin : gen_way
        bp_ram #(
            .data_width($bits(bt_entry_t)),
            .depth(`BP_ENTRIES)
        ) tag_bank (
            .clk(clk),
            .reset(reset),
            .write_addr(get_index(br_result.pc)),
            .write_en(tag_update_way[w]),
            .write_data(ex_entry),
            .read_addr(get_index(fetch_req.next_pc)),
            .read_en(fetch_req.new_mem_request),
            .read_data(if_entry[w])
        );

        bp_ram #(
            .data_width($bits(addr_t)),
            .depth(`BP_ENTRIES)
        ) target_bank (
            .clk(clk),
            .reset(reset),
            .write_addr(get_index(br_result.pc)),
            .write_en(target_update_way[w]),
            .write_data(br_result.target_pc),
            .read_addr(get_index(fetch_req.next_pc)),
            .read_en(fetch_req.new_mem_request),
            .read_data(if_target[w])
        );

        assign tag_matches[w] = if_entry[w].valid && (if_entry[w].tag == get_tag(fetch_tag.if_pc));
    end

    ////////////////////////////////////////////////////////////////////////////
    // Fetch response, one cycle after the read
    assign hit = |tag_matches;

    always_comb begin
        hit_entry = '0;
        hit_target = '0;
        for (int w = 0; w < `BP_WAYS; w++) begin
            if (tag_matches[w]) begin
                hit_entry = if_entry[w];
                hit_target = if_target[w];
            end
        end
    end

    assign table_pred.predicted_pc = hit_target;
    assign table_pred.use_prediction = hit;
    assign table_pred.is_branch = hit_entry.is_branch;
    assign table_pred.is_return = hit_entry.is_return;
    assign table_pred.is_call = hit_entry.is_call;

    // Victim way for a miss
    way_cycler #(
        .ways(`BP_WAYS)
    ) replacement (
        .clk(clk),
        .reset(reset),
        .one_hot(replacement_way)
    );

    assign meta_if.counter = hit_entry.counter;
    assign meta_if.prediction_used = hit;
    assign meta_if.update_way = hit ? tag_matches : replacement_way;

    always_ff @(posedge clk) begin
        if (fetch_tag.pc_id_assigned)
            meta_table[fetch_tag.pc_id] <= meta_if;
    end

    assign meta_ex = meta_table[br_result.id];

    ////////////////////////////////////////////////////////////////////////////
    // Resolution update
    assign ex_entry.valid = 1'b1;
    assign ex_entry.tag = get_tag(br_result.pc);
    assign ex_entry.is_branch = br_result.is_branch;
    assign ex_entry.is_return = br_result.is_return;
    assign ex_entry.is_call = br_result.is_call;

    always_comb begin
        if (!meta_ex.prediction_used) begin
            // Fresh entry starts strongly in the resolved direction
            ex_entry.counter = br_result.branch_taken ? 2'b11 : 2'b00;
        end else begin
            case (meta_ex.counter)
                2'b00: ex_entry.counter = br_result.branch_taken ? 2'b01 : 2'b00;
                2'b01: ex_entry.counter = br_result.branch_taken ? 2'b10 : 2'b00;
                2'b10: ex_entry.counter = br_result.branch_taken ? 2'b11 : 2'b01;
                default: ex_entry.counter = br_result.branch_taken ? 2'b11 : 2'b10;
            endcase
        end
    end

    // Target only rewritten when the predicted direction flips
    assign direction_changed = !meta_ex.prediction_used ||
        (meta_ex.counter[1] != ex_entry.counter[1]);

    assign tag_update_way = {`BP_WAYS{br_result.valid}} & meta_ex.update_way;
    assign target_update_way = {`BP_WAYS{direction_changed}} & tag_update_way;

    single_way_hit: assert property (@(posedge clk) disable iff (reset) $onehot0(tag_matches))
        else $error("branch_predictor hit in more than one way");

endmodule

`default_nettype wire

//--- design/branch_prediction_unit.sv
`timescale 1ns/100ps
`default_nettype none

module branch_prediction_unit
    import bp_fetch_pkg::*;
(
    input wire clk,
    input wire reset,
    input wire fetch_req_t fetch_req,
    input wire fetch_tag_t fetch_tag,
    input wire branch_result_t br_result,
    output prediction_t prediction,
    output addr_t flush_pc
);

    prediction_t table_pred;
    addr_t ras_top;
    logic ras_empty;
    logic ras_push;
    logic ras_pop;
    logic use_ras;

    branch_predictor i_predictor (
        .clk(clk),
        .reset(reset),
        .fetch_req(fetch_req),
        .fetch_tag(fetch_tag),
        .br_result(br_result),
        .table_pred(table_pred)
    );

    ////////////////////////////////////////////////////////////////////////////
    // Return address handling

    // Empty stack falls back to the table target
    assign use_ras = table_pred.use_prediction && table_pred.is_return && !ras_empty;

    // Stack moves once per fetched instruction
    assign ras_push = fetch_tag.pc_id_assigned && table_pred.use_prediction &&
        table_pred.is_call;
    assign ras_pop = fetch_tag.pc_id_assigned && use_ras;

    return_stack i_ras (
        .clk(clk),
        .reset(reset),
        .push(ras_push),
        .pop(ras_pop),
        .push_addr(fetch_tag.if_pc + 32'd4),
        .top_addr(ras_top),
        .empty(ras_empty)
    );

    // Top is read before the pop takes effect
    always_comb begin
        prediction = table_pred;
        if (use_ras)
            prediction.predicted_pc = ras_top;
    end

    assign flush_pc = br_result.target_pc;

endmodule

`default_nettype wire

//--- verif/bp_clock_gen.sv
`timescale 1ns/100ps
`default_nettype none

module bp_clock_gen (
    output logic clk,
    output logic reset
);

    // 4 ns period
    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // Reset held for the first 10 rising edges
    initial begin
        reset = 1'b1;
        repeat (10) @(posedge clk);
        #1 reset = 1'b0;
    end

endmodule

`default_nettype wire

//--- verif/bp_unit_tb.sv
`timescale 1ns/100ps
`default_nettype none

`include "bp_consts.svh"

module bp_unit_tb
    import bp_table_pkg::*;
    import bp_fetch_pkg::*;
();

    // Words per step in the tests file
    localparam int STEP_WORDS = 7;
    localparam int MAX_STEPS = 64;

    logic clk;
    logic reset;
    fetch_req_t fetch_req;
    fetch_tag_t fetch_tag;
    branch_result_t br_result;
    prediction_t prediction;
    addr_t flush_pc;

    logic [31:0] tests [STEP_WORDS * MAX_STEPS];

    int unsigned cycles = 0;
    int unsigned cycle_limit = 0;
    // Rising edges seen with reset low
    int unsigned live_edges = 0;

    bp_clock_gen i_clock (
        .clk(clk),
        .reset(reset)
    );

    branch_prediction_unit i_dut (
        .clk(clk),
        .reset(reset),
        .fetch_req(fetch_req),
        .fetch_tag(fetch_tag),
        .br_result(br_result),
        .prediction(prediction),
        .flush_pc(flush_pc)
    );

    ////////////////////////////////////////////////////////////////////////////
    // Cycle counting and timeout

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (!reset)
            live_edges <= live_edges + 1;
        if (cycle_limit != 0 && cycles >= cycle_limit) begin
            $display("Timeout: the tests did not finish within %0d cycles", cycle_limit);
            $display("Test failed");
            $fatal(1, "simulation stopped by the cycle limit");
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Helpers

    task automatic idle(input int count);
        repeat (count) begin
            @(posedge clk);
            #1;
        end
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] expected);
        assert (got === expected)
        else begin
            $display("error %s: got 0x%h, expected 0x%h", name, got, expected);
            $display("Test failed");
            $fatal(1, "stopped at the first mismatch");
        end
    endtask

    // Victim way the cycler offers at the metadata edge of a lookup started now
    function automatic way_mask_t fill_way();
        return way_mask_t'(1) << ((live_edges + 1) % `BP_WAYS);
    endfunction

    // Request in one cycle and fetch tag with response in the next
    task automatic lookup(input int base);
        instr_id_t id;
        addr_t pc;
        way_mask_t victim;
        id = instr_id_t'(tests[base + 1]);
        pc = tests[base + 2];
        victim = way_mask_t'(tests[base + 6]);
        while (victim != '0 && fill_way() != victim)
            idle(1);
        fetch_req.next_pc = pc;
        fetch_req.new_mem_request = 1'b1;
        @(posedge clk);
        #1;
        fetch_req.new_mem_request = 1'b0;
        fetch_tag.if_pc = pc;
        fetch_tag.pc_id = id;
        fetch_tag.pc_id_assigned = 1'b1;
        #1;
        check_value("use_prediction", 32'(prediction.use_prediction), tests[base + 3]);
        if (tests[base + 3] != 32'h0) begin
            check_value("predicted_pc", prediction.predicted_pc, tests[base + 4]);
            check_value("{is_branch,is_return,is_call}",
                32'({prediction.is_branch, prediction.is_return, prediction.is_call}),
                tests[base + 5]);
        end
        @(posedge clk);
        #1;
        fetch_tag.pc_id_assigned = 1'b0;
    endtask

    // Single-cycle branch result from execute
    task automatic resolve(input int base);
        br_result.valid = 1'b1;
        br_result.id = instr_id_t'(tests[base + 1]);
        br_result.pc = tests[base + 2];
        br_result.target_pc = tests[base + 3];
        br_result.branch_taken = tests[base + 4][0];
        br_result.is_branch = tests[base + 5][2];
        br_result.is_return = tests[base + 5][1];
        br_result.is_call = tests[base + 5][0];
        #1;
        check_value("flush_pc", flush_pc, tests[base + 3]);
        @(posedge clk);
        #1;
        br_result.valid = 1'b0;
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Step sequence from the tests file

    initial begin
        int steps;
        fetch_req = '0;
        fetch_tag = '0;
        br_result = '0;
        void'($urandom(32'hb4aa));
        $readmemh("verif/bp_tests.txt", tests);

        // List ends at a step of type 0
        steps = 0;
        while (steps < MAX_STEPS && tests[steps * STEP_WORDS] != 32'h0)
            steps++;

        // Missing or empty tests file
        assert (steps > 0)
        else begin
            $display("The tests file could not be read or holds no steps");
            $display("Test failed");
            $fatal(1, "no test steps loaded");
        end

        cycle_limit = steps * 5 + 100;

        @(posedge clk);
        while (reset)
            @(posedge clk);
        #1;

        for (int s = 0; s < steps; s++) begin
            if (tests[s * STEP_WORDS] == 32'h1)
                lookup(s * STEP_WORDS);
            else
                resolve(s * STEP_WORDS);
            idle(int'($urandom % 4));
        end

        $display("Test passed");
        $finish;
    end

endmodule

`default_nettype wire

//--- verif/bp_tests.txt
// Lookup:  1 id next_pc use predicted_pc {branch,return,call} fill_way (0 for any way)
// Resolve: 2 id pc target_pc taken {branch,return,call} 0, a line of zeros ends the list
// Empty table after reset
1 0 00001000 0 00000000 0 0
// Branch at 1010 learned taken, then two not-taken resolutions
1 1 00001010 0 00000000 0 0
2 1 00001010 00002000 1 4 0
1 2 00001010 1 00002000 4 0
2 2 00001010 00001014 0 4 0
1 3 00001010 1 00002000 4 0
2 3 00001010 00001014 0 4 0
1 4 00001010 1 00001014 4 0
// Two tags in set 8 fill way 0 and way 1
1 5 00001020 0 00000000 0 1
1 6 00002020 0 00000000 0 2
2 5 00001020 00003000 1 4 0
2 6 00002020 00004000 1 4 0
1 7 00001020 1 00003000 4 0
1 0 00002020 1 00004000 4 0
// Call at 1030 and return at 5040, first return with an empty stack
1 1 00001030 0 00000000 0 0
2 1 00001030 00005000 1 1 0
1 2 00005040 0 00000000 0 0
2 2 00005040 00007774 1 2 0
1 3 00005040 1 00007774 2 0
1 4 00001030 1 00005000 1 0
1 5 00005040 1 00001034 2 0
// Four more call sites, five nested calls, five returns
1 6 00001050 0 00000000 0 0
2 6 00001050 00005000 1 1 0
1 7 00001060 0 00000000 0 0
2 7 00001060 00005000 1 1 0
1 0 00001070 0 00000000 0 0
2 0 00001070 00005000 1 1 0
1 1 00001080 0 00000000 0 0
2 1 00001080 00005000 1 1 0
1 2 00001030 1 00005000 1 0
1 3 00001050 1 00005000 1 0
1 4 00001060 1 00005000 1 0
1 5 00001070 1 00005000 1 0
1 6 00001080 1 00005000 1 0
1 7 00005040 1 00001084 2 0
1 0 00005040 1 00001074 2 0
1 1 00005040 1 00001064 2 0
1 2 00005040 1 00001054 2 0
1 3 00005040 1 00007774 2 0
// End of list
0 0 00000000 0 00000000 0 0

//--- build.f
+incdir+design
design/bp_table_pkg.sv
design/bp_fetch_pkg.sv
design/bp_ram.sv
design/way_cycler.sv
design/return_stack.sv
design/branch_predictor.sv
design/branch_prediction_unit.sv
verif/bp_clock_gen.sv
verif/bp_unit_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Compile the RTL and testbench with Verilator, run, and look for the pass line

cd "$(dirname "$0")" || exit 1

verilator --binary --assert -f build.f --top-module bp_unit_tb \
    && ./obj_dir/Vbp_unit_tb | tee /dev/stderr | grep -x "Test passed" > /dev/null \
    && echo "Simulation passed" \
    || { echo "Simulation failed"; exit 1; }
